// ==== include/sum_kernel_config.svh ====
//////////////////////////////////////////////////////////////////////
// build-time constants for the sum kernel
// widths, adder depth and queue sizing, included by the package and
// by any block that sizes logic from these values
//////////////////////////////////////////////////////////////////////

`ifndef SUM_KERNEL_CONFIG_SVH
`define SUM_KERNEL_CONFIG_SVH

// vertex and edge values, and their sums
`define SK_DATA_W 32

// destination vertex index
`define SK_INDEX_W 16

// out-degree and response counter
`define SK_DEGREE_W 16

// fixed-point adder stages
`define SK_SUM_DELAY 4

// retry queue and write buffer
`define SK_BUFFER_DEPTH 16
`define SK_ALFULL_MARGIN 4

`endif

// ==== rtl/sum_kernel_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// shared types of the sum kernel
// vector typedefs sized from the config header, plus the state type
// of the write-issue merge
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "sum_kernel_config.svh"

package sum_kernel_pkg;

	// vertex value, edge value or sum
	typedef logic [`SK_DATA_W-1:0] edge_value_t;

	// destination vertex of a write
	typedef logic [`SK_INDEX_W-1:0] vertex_index_t;

	// out-degree, also the width of the response count
	typedef logic [`SK_DEGREE_W-1:0] degree_t;

	// source of the merge slot in front of the write buffer
	typedef enum logic {
		ISSUE_PIPE,
		ISSUE_RETRY
	} issue_state_t;

endpackage

`default_nettype wire

// ==== rtl/retry_if.sv ====
//////////////////////////////////////////////////////////////////////
// head of the retry queue as seen by the write-issue block
// the producer shows the head while valid, the consumer strobes take
// for one cycle to pop it
//////////////////////////////////////////////////////////////////////

`default_nettype none

interface retry_if;

	logic                          valid;
	sum_kernel_pkg::vertex_index_t index;
	sum_kernel_pkg::edge_value_t   data;
	logic                          take;

	modport producer (
		output valid,
		output index,
		output data,
		input  take
	);

	// take only while valid is high
	modport consumer (
		input  valid,
		input  index,
		input  data,
		output take
	);

endinterface

`default_nettype wire

// ==== rtl/sync_fifo.sv ====
//////////////////////////////////////////////////////////////////////
// synchronous FIFO with a registered occupancy count
// head is shown on data_out whenever not empty; push while full and
// pop while empty are dropped
//////////////////////////////////////////////////////////////////////

`default_nettype none

module sync_fifo #(
	parameter int WIDTH         = 8,
	parameter int DEPTH         = 16,
	parameter int ALFULL_MARGIN = 4
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             full,
	output logic             alfull,
	output logic             empty
);

	localparam int AW           = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW           = $clog2(DEPTH + 1);
	localparam int ALFULL_LEVEL = DEPTH - ALFULL_MARGIN;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [CW-1:0]    count;
	logic             do_push;
	logic             do_pop;

	assign do_push  = push && !full;
	assign do_pop   = pop && !empty;

	assign full     = (count == CW'(DEPTH));
	assign empty    = (count == '0);
	assign alfull   = (count >= CW'(ALFULL_LEVEL));
	assign data_out = mem[rd_ptr];

	// pointers wrap at DEPTH so any depth works
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + AW'(1);
			if (do_pop)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + AW'(1);
			if (do_push && !do_pop)
				count <= count + CW'(1);
			else if (do_pop && !do_push)
				count <= count - CW'(1);
		end
	end

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
	end

endmodule

`default_nettype wire

// ==== rtl/edge_sum_pipe.sv ====
//////////////////////////////////////////////////////////////////////
// fixed-delay sum of vertex value and edge value
// each accepted edge is latched once, then its sum travels through
// SK_SUM_DELAY adder stages together with its index and valid bit
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "sum_kernel_config.svh"

module edge_sum_pipe (
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          enable,
	input  logic                          vertex_valid,
	input  sum_kernel_pkg::edge_value_t   vertex_data,
	input  logic                          edge_valid,
	input  sum_kernel_pkg::vertex_index_t edge_index,
	input  sum_kernel_pkg::edge_value_t   edge_data,
	output logic                          sum_valid,
	output sum_kernel_pkg::vertex_index_t sum_index,
	output sum_kernel_pkg::edge_value_t   sum_data
);

	localparam int SUM_DELAY = `SK_SUM_DELAY;

	// input latch
	logic                          in_valid;
	sum_kernel_pkg::vertex_index_t in_index;
	sum_kernel_pkg::edge_value_t   in_data;
	sum_kernel_pkg::edge_value_t   in_vertex;

	// adder stages, index 0 does the add
	logic [SUM_DELAY-1:0]          stage_valid;
	sum_kernel_pkg::vertex_index_t stage_index [SUM_DELAY];
	sum_kernel_pkg::edge_value_t   stage_sum   [SUM_DELAY];

	//////////////////////////////////////////////////////////////////////
	// valid bits, flushed whenever enable drops
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			in_valid    <= 1'b0;
			stage_valid <= '0;
		end else if (!enable) begin
			in_valid    <= 1'b0;
			stage_valid <= '0;
		end else begin
			in_valid       <= vertex_valid && edge_valid;
			stage_valid[0] <= in_valid;
			for (int i = 1; i < SUM_DELAY; i++)
				stage_valid[i] <= stage_valid[i-1];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// payload, qualified by the valid bits above
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		in_index  <= edge_index;
		in_data   <= edge_data;
		in_vertex <= vertex_data;

		// wraps at SK_DATA_W bits
		stage_sum[0]   <= in_vertex + in_data;
		stage_index[0] <= in_index;
		for (int i = 1; i < SUM_DELAY; i++) begin
			stage_sum[i]   <= stage_sum[i-1];
			stage_index[i] <= stage_index[i-1];
		end
	end

	assign sum_valid = stage_valid[SUM_DELAY-1];
	assign sum_index = stage_index[SUM_DELAY-1];
	assign sum_data  = stage_sum[SUM_DELAY-1];

endmodule

`default_nettype wire

// ==== rtl/retry_capture.sv ====
//////////////////////////////////////////////////////////////////////
// write response handling
// NLOCK responses are queued for reissue and their head is offered on
// the retry interface; successful ones count toward vertex_done
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "sum_kernel_config.svh"

module retry_capture (
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          resp_valid,
	input  logic                          resp_nlock,
	input  sum_kernel_pkg::vertex_index_t resp_index,
	input  sum_kernel_pkg::edge_value_t   resp_data,
	input  sum_kernel_pkg::degree_t       vertex_out_degree,
	output logic                          vertex_done,
	retry_if.producer                     retry
);

	localparam int ENTRY_W = $bits(sum_kernel_pkg::vertex_index_t)
		+ $bits(sum_kernel_pkg::edge_value_t);

	logic                          nlock_valid;
	sum_kernel_pkg::vertex_index_t nlock_index;
	sum_kernel_pkg::edge_value_t   nlock_data;
	logic [ENTRY_W-1:0]            queue_head;
	logic                          queue_empty;
	logic                          resp_ok;
	sum_kernel_pkg::degree_t       resp_count;

	assign resp_ok = resp_valid && !resp_nlock;

	// refused write, held one cycle before it enters the queue
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			nlock_valid <= 1'b0;
		else
			nlock_valid <= resp_valid && resp_nlock;
	end

	always_ff @(posedge clock) begin
		nlock_index <= resp_index;
		nlock_data  <= resp_data;
	end

	sync_fifo #(
		.WIDTH        (ENTRY_W),
		.DEPTH        (`SK_BUFFER_DEPTH),
		.ALFULL_MARGIN(`SK_ALFULL_MARGIN)
	) u_retry_queue (
		.clock   (clock),
		.rstn    (rstn),
		.push    (nlock_valid),
		.data_in ({nlock_index, nlock_data}),
		.pop     (retry.take),
		.data_out(queue_head),
		.full    (),
		.alfull  (),
		.empty   (queue_empty)
	);

	assign retry.valid               = !queue_empty;
	assign {retry.index, retry.data} = queue_head;

	//////////////////////////////////////////////////////////////////////
	// job completion
	//////////////////////////////////////////////////////////////////////

	// a zero count never completes, so a zero out-degree stays quiet
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			resp_count  <= '0;
			vertex_done <= 1'b0;
		end else if (resp_count != '0 && resp_count == vertex_out_degree) begin
			vertex_done <= 1'b1;
			resp_count  <= resp_ok ? sum_kernel_pkg::degree_t'(1) : '0;
		end else begin
			vertex_done <= 1'b0;
			if (resp_ok)
				resp_count <= resp_count + sum_kernel_pkg::degree_t'(1);
		end
	end

endmodule

`default_nettype wire

// ==== rtl/write_issue.sv ====
//////////////////////////////////////////////////////////////////////
// merge of pipeline sums and retries into the write buffer
// pipeline sums always win the merge slot; the buffer head is
// registered onto the bus and popped by bus_grant
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "sum_kernel_config.svh"

module write_issue (
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          sum_valid,
	input  sum_kernel_pkg::vertex_index_t sum_index,
	input  sum_kernel_pkg::edge_value_t   sum_data,
	input  logic                          bus_grant,
	output logic                          bus_request,
	output logic                          write_valid,
	output sum_kernel_pkg::vertex_index_t write_index,
	output sum_kernel_pkg::edge_value_t   write_data,
	output logic                          buffer_alfull,
	retry_if.consumer                     retry
);

	localparam int ENTRY_W = $bits(sum_kernel_pkg::vertex_index_t)
		+ $bits(sum_kernel_pkg::edge_value_t);
	// room for the input latch, adder stages, merge slot and edge_request lag
	localparam int BUFFER_MARGIN = `SK_ALFULL_MARGIN + `SK_SUM_DELAY + 3;

	sum_kernel_pkg::issue_state_t  issue_state;
	sum_kernel_pkg::issue_state_t  issue_next;
	logic                          pipe_valid;
	sum_kernel_pkg::vertex_index_t pipe_index;
	sum_kernel_pkg::edge_value_t   pipe_data;
	sum_kernel_pkg::vertex_index_t retry_index;
	sum_kernel_pkg::edge_value_t   retry_data;
	logic                          buffer_push;
	logic                          buffer_pop;
	logic [ENTRY_W-1:0]            buffer_data_in;
	logic [ENTRY_W-1:0]            buffer_head;
	logic                          buffer_full;
	logic                          buffer_empty;

	//////////////////////////////////////////////////////////////////////
	// merge slot
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		issue_next = sum_kernel_pkg::ISSUE_PIPE;
		if (!sum_valid && retry.valid && !buffer_alfull)
			issue_next = sum_kernel_pkg::ISSUE_RETRY;
	end

	assign retry.take = (issue_next == sum_kernel_pkg::ISSUE_RETRY);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			issue_state <= sum_kernel_pkg::ISSUE_PIPE;
			pipe_valid  <= 1'b0;
		end else begin
			issue_state <= issue_next;
			pipe_valid  <= sum_valid;
		end
	end

	always_ff @(posedge clock) begin
		pipe_index <= sum_index;
		pipe_data  <= sum_data;
		if (retry.take) begin
			retry_index <= retry.index;
			retry_data  <= retry.data;
		end
	end

	// pipe_valid and ISSUE_RETRY never coincide
	assign buffer_push    = pipe_valid || (issue_state == sum_kernel_pkg::ISSUE_RETRY);
	assign buffer_data_in = (issue_state == sum_kernel_pkg::ISSUE_RETRY)
		? {retry_index, retry_data} : {pipe_index, pipe_data};

	sync_fifo #(
		.WIDTH        (ENTRY_W),
		.DEPTH        (`SK_BUFFER_DEPTH),
		.ALFULL_MARGIN(BUFFER_MARGIN)
	) u_write_buffer (
		.clock   (clock),
		.rstn    (rstn),
		.push    (buffer_push),
		.data_in (buffer_data_in),
		.pop     (buffer_pop),
		.data_out(buffer_head),
		.full    (buffer_full),
		.alfull  (buffer_alfull),
		.empty   (buffer_empty)
	);

	//////////////////////////////////////////////////////////////////////
	// bus side
	//////////////////////////////////////////////////////////////////////

	assign buffer_pop = bus_grant && bus_request;

	// drop request for one cycle after a grant so the next head can settle
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			bus_request <= 1'b0;
		else if (buffer_pop)
			bus_request <= 1'b0;
		else
			bus_request <= !buffer_empty;
	end

	always_ff @(posedge clock) begin
		{write_index, write_data} <= buffer_head;
	end

	assign write_valid = bus_request;

endmodule

`default_nettype wire

// ==== rtl/sum_kernel_top.sv ====
//////////////////////////////////////////////////////////////////////
// sum kernel top level
// edges in, sums out as bus writes, NLOCK responses reissued, and a
// vertex_done pulse once the out-degree is answered
//////////////////////////////////////////////////////////////////////

`default_nettype none

module sum_kernel_top (
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          enable,
	input  logic                          vertex_valid,
	input  sum_kernel_pkg::edge_value_t   vertex_data,
	input  sum_kernel_pkg::degree_t       vertex_out_degree,
	input  logic                          edge_valid,
	input  sum_kernel_pkg::vertex_index_t edge_index,
	input  sum_kernel_pkg::edge_value_t   edge_data,
	input  logic                          resp_valid,
	input  logic                          resp_nlock,
	input  sum_kernel_pkg::vertex_index_t resp_index,
	input  sum_kernel_pkg::edge_value_t   resp_data,
	input  logic                          bus_grant,
	output logic                          edge_request,
	output logic                          bus_request,
	output logic                          write_valid,
	output sum_kernel_pkg::vertex_index_t write_index,
	output sum_kernel_pkg::edge_value_t   write_data,
	output logic                          vertex_done
);

	logic                          sum_valid;
	sum_kernel_pkg::vertex_index_t sum_index;
	sum_kernel_pkg::edge_value_t   sum_data;
	logic                          buffer_alfull;

	retry_if retry_bus ();

	edge_sum_pipe u_edge_sum_pipe (
		.clock       (clock),
		.rstn        (rstn),
		.enable      (enable),
		.vertex_valid(vertex_valid),
		.vertex_data (vertex_data),
		.edge_valid  (edge_valid),
		.edge_index  (edge_index),
		.edge_data   (edge_data),
		.sum_valid   (sum_valid),
		.sum_index   (sum_index),
		.sum_data    (sum_data)
	);

	retry_capture u_retry_capture (
		.clock            (clock),
		.rstn             (rstn),
		.resp_valid       (resp_valid),
		.resp_nlock       (resp_nlock),
		.resp_index       (resp_index),
		.resp_data        (resp_data),
		.vertex_out_degree(vertex_out_degree),
		.vertex_done      (vertex_done),
		.retry            (retry_bus.producer)
	);

	write_issue u_write_issue (
		.clock        (clock),
		.rstn         (rstn),
		.sum_valid    (sum_valid),
		.sum_index    (sum_index),
		.sum_data     (sum_data),
		.bus_grant    (bus_grant),
		.bus_request  (bus_request),
		.write_valid  (write_valid),
		.write_index  (write_index),
		.write_data   (write_data),
		.buffer_alfull(buffer_alfull),
		.retry        (retry_bus.consumer)
	);

	// edge throttle, the pipeline itself cannot stall
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			edge_request <= 1'b0;
		else
			edge_request <= enable && !buffer_alfull;
	end

endmodule

`default_nettype wire

// ==== bench/sum_kernel_sva.sv ====
//////////////////////////////////////////////////////////////////////
// concurrent checks on the write-issue block
// bound into every write_issue instance, watches the retry handshake
// and the write buffer flags
//////////////////////////////////////////////////////////////////////

`default_nettype none

module write_issue_sva (
	input logic clock,
	input logic rstn,
	input logic take,
	input logic valid,
	input logic bus_request,
	input logic buffer_empty,
	input logic buffer_push,
	input logic buffer_full
);

	// retry head popped only while one is shown
	take_needs_valid: assert property (@(posedge clock) disable iff (!rstn)
		take |-> valid)
		else $error("retry take raised without a valid retry head");

	request_needs_entry: assert property (@(posedge clock) disable iff (!rstn)
		buffer_empty |-> !bus_request)
		else $error("bus_request high with an empty write buffer");

	// the almost-full margin must keep the buffer from overflowing
	no_push_when_full: assert property (@(posedge clock) disable iff (!rstn)
		buffer_full |-> !buffer_push)
		else $error("write buffer pushed while full");

endmodule

bind write_issue write_issue_sva u_write_issue_sva (
	.clock       (clock),
	.rstn        (rstn),
	.take        (retry.take),
	.valid       (retry.valid),
	.bus_request (bus_request),
	.buffer_empty(buffer_empty),
	.buffer_push (buffer_push),
	.buffer_full (buffer_full)
);

`default_nettype wire

// ==== bench/sum_kernel_tb.sv ====
//////////////////////////////////////////////////////////////////////
// testbench for the sum kernel
// a table of vertex jobs is applied in a loop; the bench plays the bus
// and the memory, predicting every write and the vertex_done pulse
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "sum_kernel_config.svh"

module sum_kernel_tb;

	localparam int ENTRY_W      = `SK_INDEX_W + `SK_DATA_W;
	localparam int LATENCY      = `SK_SUM_DELAY + 3;
	localparam int TAIL         = `SK_SUM_DELAY + 6;
	localparam int GRANT_ALWAYS = 0;
	localparam int GRANT_RANDOM = 1;
	localparam int GRANT_HOLD   = 2;

	logic                          clock;
	logic                          rstn;
	logic                          enable;
	logic                          vertex_valid;
	logic                          edge_valid;
	logic                          resp_valid;
	logic                          resp_nlock;
	logic                          bus_grant;
	sum_kernel_pkg::edge_value_t   vertex_data;
	sum_kernel_pkg::edge_value_t   edge_data;
	sum_kernel_pkg::edge_value_t   resp_data;
	sum_kernel_pkg::edge_value_t   write_data;
	sum_kernel_pkg::degree_t       vertex_out_degree;
	sum_kernel_pkg::vertex_index_t edge_index;
	sum_kernel_pkg::vertex_index_t resp_index;
	sum_kernel_pkg::vertex_index_t write_index;
	logic                          edge_request;
	logic                          bus_request;
	logic                          write_valid;
	logic                          vertex_done;

	// test table with one entry per vertex job
	string                         test_name   [$];
	sum_kernel_pkg::edge_value_t   test_vertex [$];
	sum_kernel_pkg::degree_t       test_degree [$];
	logic [15:0]                   test_nlock  [$];
	int                            test_grant  [$];
	bit                            test_enable [$];
	int                            test_first  [$];
	int                            test_count  [$];
	sum_kernel_pkg::vertex_index_t edge_index_tab [$];
	sum_kernel_pkg::edge_value_t   edge_data_tab  [$];

	// reference model of predicted writes and the cycle that caused each
	logic [ENTRY_W-1:0] pipe_q [$];
	int                 pipe_cycle_q [$];
	logic [ENTRY_W-1:0] retry_q [$];
	int                 retry_cycle_q [$];

	int    cycle = 0;
	int    limit = 0;
	int    errors = 0;
	int    checks = 0;
	int    cur;
	string cur_name = "reset";
	int    edges_sent;
	int    resp_total;
	int    success_total;
	int    done_pulses;
	int    writes_seen;
	int    retries_seen;
	int    expect_done;
	int    first_edge_cycle;
	bit    first_write_seen;
	bit    throttle_seen;

	sum_kernel_top u_sum_kernel_top (.*);

	always #10 clock = ~clock;

	// watchdog
	always @(posedge clock) begin
		cycle <= cycle + 1;
		if (limit > 0 && cycle >= limit) begin
			$display("timeout after %0d cycles with writes still pending", cycle);
			$display("Finished with errors");
			$finish;
		end
	end

	task automatic report_mismatch(input string what, input logic [63:0] expected,
			input logic [63:0] actual);
		$display("error %s %s expected %0h actual %0h", cur_name, what, expected, actual);
		errors++;
	endtask

	task automatic report_failure(input string text);
		$display("%s: %s", cur_name, text);
		errors++;
	endtask

	task automatic open_test(input string name, input sum_kernel_pkg::edge_value_t vertex,
			input sum_kernel_pkg::degree_t degree, input logic [15:0] nlock,
			input int grant, input bit en);
		test_name.push_back(name);
		test_vertex.push_back(vertex);
		test_degree.push_back(degree);
		test_nlock.push_back(nlock);
		test_grant.push_back(grant);
		test_enable.push_back(en);
		test_first.push_back(edge_index_tab.size());
		test_count.push_back(0);
	endtask

	task automatic add_edge(input sum_kernel_pkg::vertex_index_t idx,
			input sum_kernel_pkg::edge_value_t data);
		edge_index_tab.push_back(idx);
		edge_data_tab.push_back(data);
		test_count[test_count.size() - 1] += 1;
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus table
	//////////////////////////////////////////////////////////////////////

	task automatic load_table();
		open_test("lone_edge", 32'h0000_1000, 16'd1, 16'h0000, GRANT_ALWAYS, 1'b1);
		add_edge(16'h0011, 32'h0000_0234);
		// sums past 2^32 wrap
		open_test("sum_wrap", 32'hffff_fff0, 16'd4, 16'h0000, GRANT_RANDOM, 1'b1);
		add_edge(16'h0100, 32'h0000_0010);
		add_edge(16'h0101, 32'h0000_0025);
		add_edge(16'h0102, 32'h8000_0000);
		add_edge(16'h0103, 32'h0000_0001);
		open_test("nlock_retry", 32'h1234_0000, 16'd6, 16'h0005, GRANT_ALWAYS, 1'b1);
		for (int i = 0; i < 6; i++)
			add_edge(16'h0200 + 16'(i), 32'h0000_1100 * 32'(i + 1));
		// more edges than the write buffer holds
		open_test("throttle", 32'h0bad_0000, 16'd24, 16'h0012, GRANT_HOLD, 1'b1);
		for (int i = 0; i < 24; i++)
			add_edge(16'h0300 + 16'(i), $urandom);
		open_test("disabled", 32'h5555_0000, 16'd0, 16'h0000, GRANT_ALWAYS, 1'b0);
		for (int i = 0; i < 3; i++)
			add_edge(16'h0400 + 16'(i), 32'h0000_0040 + 32'(i));
		open_test("after_disable", 32'h0000_0001, 16'd3, 16'h0002, GRANT_RANDOM, 1'b1);
		for (int i = 0; i < 3; i++)
			add_edge(16'h0500 + 16'(i), 32'h7fff_fff0 + 32'(i));
	endtask

	function automatic bit grant_decision();
		case (test_grant[cur])
			GRANT_ALWAYS: return 1'b1;
			// grants held back until the edge stream is throttled
			GRANT_HOLD:   return throttle_seen && ($urandom % 2 == 0);
			default:      return ($urandom % 2 == 0);
		endcase
	endfunction

	task automatic check_write(input logic [ENTRY_W-1:0] entry);
		checks++;
		writes_seen++;
		if (retry_q.size() != 0 && entry == retry_q[0]) begin
			// pipeline writes sampled three or more cycles before the NLOCK go first
			if (pipe_cycle_q.size() != 0)
				assert (pipe_cycle_q[0] > retry_cycle_q[0] - 3)
				else report_failure("retry overtook an earlier pipeline write");
			void'(retry_q.pop_front());
			void'(retry_cycle_q.pop_front());
			retries_seen++;
		end else begin
			assert (pipe_q.size() != 0)
			else report_failure("write seen with no edge or retry pending");
			if (pipe_q.size() != 0) begin
				assert (entry == pipe_q[0])
				else report_mismatch("write", 64'(pipe_q[0]), 64'(entry));
				void'(pipe_q.pop_front());
				void'(pipe_cycle_q.pop_front());
			end
		end
	endtask

	// memory response to a granted write
	task automatic answer_write(input logic [ENTRY_W-1:0] entry);
		resp_valid = 1'b1;
		{resp_index, resp_data} = entry;
		resp_nlock = (resp_total < 16) ? test_nlock[cur][4'(resp_total)] : 1'b0;
		resp_total++;
		if (resp_nlock) begin
			retry_q.push_back(entry);
			retry_cycle_q.push_back(cycle + 1);
		end else begin
			success_total++;
			if (success_total == int'(test_degree[cur]))
				expect_done = cycle + 2;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// one falling edge that monitors outputs and then drives the next inputs
	//////////////////////////////////////////////////////////////////////

	task automatic service_cycle();
		logic [ENTRY_W-1:0] entry;
		int                 k;
		bus_grant  = 1'b0;
		resp_valid = 1'b0;
		resp_nlock = 1'b0;
		edge_valid = 1'b0;
		if (vertex_done) begin
			done_pulses++;
			checks++;
			assert (cycle == expect_done)
			else report_mismatch("vertex_done cycle", 64'(expect_done), 64'(cycle));
		end
		if (!enable) begin
			checks++;
			assert (!edge_request)
			else report_failure("edge_request high while the kernel is disabled");
		end
		assert (bus_request == write_valid)
		else report_failure("bus_request and write_valid disagree");
		assert (pipe_q.size() <= `SK_BUFFER_DEPTH)
		else report_failure("more writes in flight than the write buffer holds");

		if (write_valid) begin
			if (!first_write_seen) begin
				first_write_seen = 1'b1;
				checks++;
				assert (cycle - first_edge_cycle == LATENCY)
				else report_mismatch("latency", 64'(LATENCY), 64'(cycle - first_edge_cycle));
			end
			if (grant_decision()) begin
				entry = {write_index, write_data};
				check_write(entry);
				answer_write(entry);
				bus_grant = 1'b1;
			end
		end

		if (edges_sent < test_count[cur]) begin
			k = test_first[cur] + edges_sent;
			if (!enable || edge_request) begin
				edge_valid = 1'b1;
				edge_index = edge_index_tab[k];
				edge_data  = edge_data_tab[k];
				if (enable) begin
					pipe_q.push_back({edge_index_tab[k],
						sum_kernel_pkg::edge_value_t'(vertex_data + edge_data_tab[k])});
					pipe_cycle_q.push_back(cycle + 1);
					if (first_edge_cycle < 0)
						first_edge_cycle = cycle + 1;
				end
				edges_sent++;
			end else begin
				throttle_seen = 1'b1;
			end
		end
	endtask

	task automatic run_test(input int t);
		int errors_before;
		cur              = t;
		cur_name         = test_name[t];
		errors_before    = errors;
		edges_sent       = 0;
		resp_total       = 0;
		success_total    = 0;
		done_pulses      = 0;
		writes_seen      = 0;
		retries_seen     = 0;
		expect_done      = -1;
		first_edge_cycle = -1;
		first_write_seen = 1'b0;
		throttle_seen    = 1'b0;
		enable            = test_enable[t];
		vertex_valid      = 1'b1;
		vertex_data       = test_vertex[t];
		vertex_out_degree = test_degree[t];
		@(negedge clock);
		while (edges_sent < test_count[t] || pipe_q.size() != 0 || retry_q.size() != 0) begin
			service_cycle();
			@(negedge clock);
		end
		// late done pulse and stray writes
		repeat (TAIL) begin
			service_cycle();
			@(negedge clock);
		end
		checks++;
		assert (done_pulses == ((test_degree[t] != 0) ? 1 : 0))
		else report_mismatch("done pulses", 64'((test_degree[t] != 0) ? 1 : 0),
			64'(done_pulses));
		if (test_grant[t] == GRANT_HOLD) begin
			checks++;
			assert (throttle_seen)
			else report_failure("edge_request never fell while grants were withheld");
		end
		$display("test %s edges %0d writes %0d retries %0d done %0d errors %0d", cur_name,
			test_count[t], writes_seen, retries_seen, done_pulses, errors - errors_before);
	endtask

	initial begin
		clock             = 1'b0;
		rstn              = 1'b0;
		enable            = 1'b0;
		vertex_valid      = 1'b0;
		vertex_data       = '0;
		vertex_out_degree = '0;
		edge_valid        = 1'b0;
		edge_index        = '0;
		edge_data         = '0;
		resp_valid        = 1'b0;
		resp_nlock        = 1'b0;
		resp_index        = '0;
		resp_data         = '0;
		bus_grant         = 1'b0;
		void'($urandom(32'h1df00734));
		load_table();
		limit = edge_index_tab.size() * (`SK_SUM_DELAY + `SK_BUFFER_DEPTH + 8);

		repeat (16) @(negedge clock);
		checks++;
		assert (!bus_request && !write_valid && !edge_request && !vertex_done)
		else report_failure("outputs not low during reset");
		rstn = 1'b1;
		@(negedge clock);

		for (int t = 0; t < test_name.size(); t++)
			run_test(t);

		$display("tests %0d checks %0d errors %0d", test_name.size(), checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
rtl/sum_kernel_pkg.sv
rtl/retry_if.sv
rtl/sync_fifo.sv
rtl/edge_sum_pipe.sv
rtl/retry_capture.sv
rtl/write_issue.sv
rtl/sum_kernel_top.sv
bench/sum_kernel_sva.sv
bench/sum_kernel_tb.sv

// ==== Makefile ====
# Verilator build and run of the sum kernel testbench
# override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= sum_kernel_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(wildcard rtl/*.sv bench/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "Finished with no errors" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
